//--- src/lorenz_pkg.sv
`default_nettype none

package lorenz_pkg;

	//////////////////////////////
	// fixed point 7.20
	//////////////////////////////

	// total width and fraction bits of a state value
	localparam int FIX_W = 27;
	localparam int FRAC_W = 20;

	// dt of 1/256 as an arithmetic shift
	localparam int DT_SHIFT = 8;

	typedef logic signed [FIX_W-1:0] fix_t;

	//////////////////////////////
	// audio path
	//////////////////////////////

	// dds phase and increment
	typedef logic [31:0] phase_t;

	// one sine sample from the rom
	typedef logic signed [15:0] sine_t;

	// word handed to the audio sink
	typedef logic [31:0] sample_t;

	// gain of each voice before summing
	localparam int MIX_SHIFT = 10;

	// note index sits in state bits 25..20
	localparam int NOTE_LSB = 20;

	typedef enum logic {
		LEFT  = 1'b0,
		RIGHT = 1'b1
	} channel_e;

	// 7.20 signed multiply
	// keep sign plus the 26 bits around the binary point
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*FIX_W-1:0] prod;
		prod = a * b;
		return {prod[2*FIX_W-1], prod[FIX_W+FRAC_W-2:FRAC_W]};
	endfunction

endpackage

`default_nettype wire

//--- src/solver_if.sv
`default_nettype none

// lorenz state and the per-frame step strobe
interface solver_if;

	// one-cycle step, one per audio frame
	logic step;

	// current state of the attractor
	lorenz_pkg::fix_t x;
	lorenz_pkg::fix_t y;
	lorenz_pkg::fix_t z;

	// integrator side
	modport solver (input step, output x, output y, output z);

	// frame control side
	modport sequencer (output step, input x, input y, input z);

endinterface

`default_nettype wire

//--- src/lorenz_solver.sv
`default_nettype none

module lorenz_solver (
	input  logic             CLOCK_50,
	input  logic             reset,
	input  logic             run,
	input  lorenz_pkg::fix_t x_init,
	input  lorenz_pkg::fix_t y_init,
	input  lorenz_pkg::fix_t z_init,
	input  lorenz_pkg::fix_t sigma,
	input  lorenz_pkg::fix_t rho,
	input  lorenz_pkg::fix_t beta,
	solver_if.solver         sv
);

	// state registers
	lorenz_pkg::fix_t x_q;
	lorenz_pkg::fix_t y_q;
	lorenz_pkg::fix_t z_q;

	// partial terms
	lorenz_pkg::fix_t y_minus_x;
	lorenz_pkg::fix_t rho_minus_z;
	lorenz_pkg::fix_t y_dt;
	lorenz_pkg::fix_t z_dt;

	// derivatives already scaled by dt
	lorenz_pkg::fix_t dx;
	lorenz_pkg::fix_t dy;
	lorenz_pkg::fix_t dz;

	//////////////////////////////
	// derivatives
	//////////////////////////////

	// differences wrap in 27 bits before the shift
	assign y_minus_x = y_q - x_q;
	assign rho_minus_z = rho - z_q;

	// dt applied by arithmetic shift
	assign y_dt = y_q >>> lorenz_pkg::DT_SHIFT;
	assign z_dt = z_q >>> lorenz_pkg::DT_SHIFT;

	// sigma * (y - x) * dt
	assign dx = lorenz_pkg::fix_mul(sigma, y_minus_x >>> lorenz_pkg::DT_SHIFT);

	// x * (rho - z) * dt - y * dt
	assign dy = lorenz_pkg::fix_mul(x_q, rho_minus_z >>> lorenz_pkg::DT_SHIFT) - y_dt;

	// x * y * dt - beta * z * dt
	assign dz = lorenz_pkg::fix_mul(x_q, y_dt) - lorenz_pkg::fix_mul(beta, z_dt);

	//////////////////////////////
	// forward euler
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			// restart from the initial point
			x_q <= x_init;
			y_q <= y_init;
			z_q <= z_init;
		end else if (sv.step && run) begin
			// one step per frame
			x_q <= x_q + dx;
			y_q <= y_q + dy;
			z_q <= z_q + dz;
		end
	end

	// export state
	assign sv.x = x_q;
	assign sv.y = y_q;
	assign sv.z = z_q;

endmodule

`default_nettype wire

//--- src/note_lut.sv
`default_nettype none

// note index to dds increment
// 52 notes, silence above the table
module note_lut (
	input  logic [5:0]         note,
	output lorenz_pkg::phase_t increment
);

	always_comb begin
		case (note)
			6'd0:  increment = 32'd2460658;
			6'd1:  increment = 32'd2762200;
			6'd2:  increment = 32'd2925946;
			6'd3:  increment = 32'd3284755;
			6'd4:  increment = 32'd3686513;
			6'd5:  increment = 32'd3905735;
			6'd6:  increment = 32'd4384445;
			6'd7:  increment = 32'd4921316;
			6'd8:  increment = 32'd5524401;
			6'd9:  increment = 32'd5852787;
			6'd10: increment = 32'd6569510;
			6'd11: increment = 32'd7373921;
			// second octave
			6'd12: increment = 32'd7812366;
			6'd13: increment = 32'd8768891;
			6'd14: increment = 32'd9842633;
			6'd15: increment = 32'd11047908;
			6'd16: increment = 32'd11704680;
			6'd17: increment = 32'd13138126;
			6'd18: increment = 32'd14746949;
			6'd19: increment = 32'd15623838;
			6'd20: increment = 32'd17537783;
			6'd21: increment = 32'd19685266;
			6'd22: increment = 32'd22095817;
			6'd23: increment = 32'd23410256;
			6'd24: increment = 32'd26276252;
			6'd25: increment = 32'd29494793;
			6'd26: increment = 32'd31248571;
			6'd27: increment = 32'd35075566;
			6'd28: increment = 32'd39370533;
			6'd29: increment = 32'd44191634;
			6'd30: increment = 32'd46819617;
			6'd31: increment = 32'd52553398;
			// upper register
			6'd32: increment = 32'd58988691;
			6'd33: increment = 32'd62497142;
			6'd34: increment = 32'd70150237;
			6'd35: increment = 32'd78741067;
			6'd36: increment = 32'd88384163;
			6'd37: increment = 32'd93639234;
			6'd38: increment = 32'd105106797;
			6'd39: increment = 32'd117978277;
			6'd40: increment = 32'd124993390;
			6'd41: increment = 32'd140300475;
			6'd42: increment = 32'd157482134;
			6'd43: increment = 32'd176767432;
			6'd44: increment = 32'd187278469;
			6'd45: increment = 32'd210213595;
			6'd46: increment = 32'd235956555;
			6'd47: increment = 32'd249987676;
			6'd48: increment = 32'd280600950;
			6'd49: increment = 32'd314964268;
			6'd50: increment = 32'd353535759;
			6'd51: increment = 32'd374557834;
			// out of range, voice stands still
			default: increment = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/sine_voice.sv
`default_nettype none

module sine_voice (
	input  logic               CLOCK_50,
	input  logic               reset,
	input  logic               advance,
	input  lorenz_pkg::phase_t increment,
	output lorenz_pkg::sine_t  sine
);

	lorenz_pkg::phase_t phase;

	// rom address from the phase msbs
	logic [7:0] addr;
	logic [6:0] quarter_idx;
	lorenz_pkg::sine_t quarter;
	lorenz_pkg::sine_t folded;

	//////////////////////////////
	// phase accumulator
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			phase <= '0;
		end else if (advance) begin
			// once per frame
			phase <= phase + increment;
		end
	end

	assign addr = phase[31:24];

	// mirror in quarters two and four
	assign quarter_idx = addr[6] ? (7'd64 - {1'b0, addr[5:0]}) : {1'b0, addr[5:0]};

	//////////////////////////////
	// quarter wave, 0 to pi/2
	//////////////////////////////

	always_comb begin
		case (quarter_idx)
			7'd0:  quarter = 16'h0000;
			7'd1:  quarter = 16'h0192;
			7'd2:  quarter = 16'h0323;
			7'd3:  quarter = 16'h04b5;
			7'd4:  quarter = 16'h0645;
			7'd5:  quarter = 16'h07d5;
			7'd6:  quarter = 16'h0963;
			7'd7:  quarter = 16'h0af0;
			7'd8:  quarter = 16'h0c7c;
			7'd9:  quarter = 16'h0e05;
			7'd10: quarter = 16'h0f8c;
			7'd11: quarter = 16'h1111;
			7'd12: quarter = 16'h1293;
			7'd13: quarter = 16'h1413;
			7'd14: quarter = 16'h158f;
			7'd15: quarter = 16'h1708;
			7'd16: quarter = 16'h187d;
			7'd17: quarter = 16'h19ef;
			7'd18: quarter = 16'h1b5c;
			7'd19: quarter = 16'h1cc5;
			7'd20: quarter = 16'h1e2a;
			7'd21: quarter = 16'h1f8b;
			7'd22: quarter = 16'h20e6;
			7'd23: quarter = 16'h223c;
			7'd24: quarter = 16'h238d;
			7'd25: quarter = 16'h24d9;
			7'd26: quarter = 16'h261f;
			7'd27: quarter = 16'h275f;
			7'd28: quarter = 16'h2899;
			7'd29: quarter = 16'h29cc;
			7'd30: quarter = 16'h2afa;
			7'd31: quarter = 16'h2c20;
			7'd32: quarter = 16'h2d40;
			7'd33: quarter = 16'h2e59;
			7'd34: quarter = 16'h2f6b;
			7'd35: quarter = 16'h3075;
			7'd36: quarter = 16'h3178;
			7'd37: quarter = 16'h3273;
			7'd38: quarter = 16'h3366;
			7'd39: quarter = 16'h3452;
			7'd40: quarter = 16'h3535;
			7'd41: quarter = 16'h3611;
			7'd42: quarter = 16'h36e4;
			7'd43: quarter = 16'h37ae;
			7'd44: quarter = 16'h3870;
			7'd45: quarter = 16'h3929;
			7'd46: quarter = 16'h39da;
			7'd47: quarter = 16'h3a81;
			7'd48: quarter = 16'h3b1f;
			7'd49: quarter = 16'h3bb5;
			7'd50: quarter = 16'h3c41;
			7'd51: quarter = 16'h3cc4;
			7'd52: quarter = 16'h3d3d;
			7'd53: quarter = 16'h3dad;
			7'd54: quarter = 16'h3e14;
			7'd55: quarter = 16'h3e70;
			7'd56: quarter = 16'h3ec4;
			7'd57: quarter = 16'h3f0d;
			7'd58: quarter = 16'h3f4d;
			7'd59: quarter = 16'h3f83;
			7'd60: quarter = 16'h3fb0;
			7'd61: quarter = 16'h3fd2;
			7'd62: quarter = 16'h3feb;
			7'd63: quarter = 16'h3ffa;
			7'd64: quarter = 16'h3fff;
			default: quarter = 16'h0000;
		endcase
	end

	// negative half cycle
	assign folded = addr[7] ? -quarter : quarter;

	// registered rom output, follows the phase every cycle
	always_ff @(posedge CLOCK_50) begin
		sine <= folded;
	end

endmodule

`default_nettype wire

//--- src/sample_sequencer.sv
`default_nettype none

module sample_sequencer (
	input  logic                 CLOCK_50,
	input  logic                 reset,
	solver_if.sequencer          sv,
	output logic                 advance,
	input  lorenz_pkg::sine_t    sine_x,
	input  lorenz_pkg::sine_t    sine_y,
	input  lorenz_pkg::sine_t    sine_z,
	output lorenz_pkg::sample_t  sample,
	output lorenz_pkg::channel_e channel,
	output logic                 sample_req,
	input  logic                 sample_ack
);

	typedef enum logic [2:0] {
		S_ADVANCE,
		S_ROM_WAIT,
		S_MIX,
		S_LEFT_REQ,
		S_LEFT_REL,
		S_RIGHT_REQ,
		S_RIGHT_REL
	} seq_state_e;

	seq_state_e state;

	// frame mix held through both handshakes
	lorenz_pkg::sample_t mix_q;

	// sign extend, then apply voice gain
	function automatic lorenz_pkg::sample_t scale(input lorenz_pkg::sine_t s);
		logic signed [31:0] wide;
		wide = s;
		return lorenz_pkg::sample_t'(wide <<< lorenz_pkg::MIX_SHIFT);
	endfunction

	// one pulse per frame to solver and voices
	assign advance = (state == S_ADVANCE);
	assign sv.step = advance;

	assign sample = mix_q;
	assign channel = (state == S_RIGHT_REQ || state == S_RIGHT_REL) ?
		lorenz_pkg::RIGHT : lorenz_pkg::LEFT;

	//////////////////////////////
	// frame fsm
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			state <= S_ADVANCE;
			sample_req <= 1'b0;
		end else begin
			case (state)
				// phases step on this edge
				S_ADVANCE: state <= S_ROM_WAIT;
				// rom register catches the new phase
				S_ROM_WAIT: state <= S_MIX;
				S_MIX: state <= S_LEFT_REQ;
				// same four phase req/ack for both words
				S_LEFT_REQ, S_RIGHT_REQ: begin
					if (!sample_req && !sample_ack) begin
						sample_req <= 1'b1;
					end else if (sample_req && sample_ack) begin
						sample_req <= 1'b0;
						state <= (state == S_LEFT_REQ) ? S_LEFT_REL : S_RIGHT_REL;
					end
				end
				// wait for the sink to drop ack
				S_LEFT_REL: begin
					if (!sample_ack) begin
						state <= S_RIGHT_REQ;
					end
				end
				S_RIGHT_REL: begin
					if (!sample_ack) begin
						state <= S_ADVANCE;
					end
				end
				default: state <= S_ADVANCE;
			endcase
		end
	end

	// sum of the three voices while the sines are valid
	always_ff @(posedge CLOCK_50) begin
		if (state == S_MIX) begin
			mix_q <= scale(sine_x) + scale(sine_y) + scale(sine_z);
		end
	end

endmodule

`default_nettype wire

//--- src/lorenz_audio.sv
`default_nettype none

module lorenz_audio (
	input  logic                 CLOCK_50,
	input  logic                 reset,
	input  logic                 run,
	input  lorenz_pkg::fix_t     x_init,
	input  lorenz_pkg::fix_t     y_init,
	input  lorenz_pkg::fix_t     z_init,
	input  lorenz_pkg::fix_t     sigma,
	input  lorenz_pkg::fix_t     rho,
	input  lorenz_pkg::fix_t     beta,
	output lorenz_pkg::fix_t     state_x,
	output lorenz_pkg::fix_t     state_y,
	output lorenz_pkg::fix_t     state_z,
	output lorenz_pkg::sample_t  sample,
	output lorenz_pkg::channel_e channel,
	output logic                 sample_req,
	input  logic                 sample_ack
);

	solver_if solver_bus ();

	logic advance;

	// per voice dds increment and sine
	lorenz_pkg::phase_t incr_x;
	lorenz_pkg::phase_t incr_y;
	lorenz_pkg::phase_t incr_z;
	lorenz_pkg::sine_t sine_x;
	lorenz_pkg::sine_t sine_y;
	lorenz_pkg::sine_t sine_z;

	//////////////////////////////
	// attractor
	//////////////////////////////

	lorenz_solver u_solver (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.run      (run),
		.x_init   (x_init),
		.y_init   (y_init),
		.z_init   (z_init),
		.sigma    (sigma),
		.rho      (rho),
		.beta     (beta),
		.sv       (solver_bus.solver)
	);

	assign state_x = solver_bus.x;
	assign state_y = solver_bus.y;
	assign state_z = solver_bus.z;

	//////////////////////////////
	// voices
	//////////////////////////////

	// six bit note index from each state variable
	note_lut u_note_x (.note(solver_bus.x[lorenz_pkg::NOTE_LSB +: 6]), .increment(incr_x));
	note_lut u_note_y (.note(solver_bus.y[lorenz_pkg::NOTE_LSB +: 6]), .increment(incr_y));
	note_lut u_note_z (.note(solver_bus.z[lorenz_pkg::NOTE_LSB +: 6]), .increment(incr_z));

	sine_voice u_voice_x (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.advance   (advance),
		.increment (incr_x),
		.sine      (sine_x)
	);

	sine_voice u_voice_y (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.advance   (advance),
		.increment (incr_y),
		.sine      (sine_y)
	);

	sine_voice u_voice_z (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.advance   (advance),
		.increment (incr_z),
		.sine      (sine_z)
	);

	// frame timing, mix and sample handshake
	sample_sequencer u_sequencer (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.sv         (solver_bus.sequencer),
		.advance    (advance),
		.sine_x     (sine_x),
		.sine_y     (sine_y),
		.sine_z     (sine_z),
		.sample     (sample),
		.channel    (channel),
		.sample_req (sample_req),
		.sample_ack (sample_ack)
	);

endmodule

`default_nettype wire

//--- verification/lorenz_audio_tb.sv
`default_nettype none

module lorenz_audio_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HEADER_WORDS = 7;
	localparam int FRAME_WORDS = 7;
	localparam int MAX_WORDS = 64;
	localparam int WAIT_LIMIT = 200;
	localparam int ACK_HOLD = 2;

	logic CLOCK_50;
	logic reset;
	logic run;
	lorenz_pkg::fix_t x_init;
	lorenz_pkg::fix_t y_init;
	lorenz_pkg::fix_t z_init;
	lorenz_pkg::fix_t sigma;
	lorenz_pkg::fix_t rho;
	lorenz_pkg::fix_t beta;
	lorenz_pkg::fix_t state_x;
	lorenz_pkg::fix_t state_y;
	lorenz_pkg::fix_t state_z;
	lorenz_pkg::sample_t sample;
	lorenz_pkg::channel_e channel;
	logic sample_req;
	logic sample_ack;

	// raw trace words
	logic [31:0] trace_mem [0:MAX_WORDS-1];

	int mismatches;
	int failures;
	logic abort_run;
	logic req_prev;
	logic ack_prev;

	lorenz_audio uut (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.run        (run),
		.x_init     (x_init),
		.y_init     (y_init),
		.z_init     (z_init),
		.sigma      (sigma),
		.rho        (rho),
		.beta       (beta),
		.state_x    (state_x),
		.state_y    (state_y),
		.state_z    (state_z),
		.sample     (sample),
		.channel    (channel),
		.sample_req (sample_req),
		.sample_ack (sample_ack)
	);

	// 50 MHz
	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// drive point just after the rising edge
	task automatic tick();
		@(posedge CLOCK_50);
		#2;
	endtask

	function automatic lorenz_pkg::fix_t word_to_fix(input logic [31:0] w);
		return lorenz_pkg::fix_t'(w[lorenz_pkg::FIX_W-1:0]);
	endfunction

	task automatic compare_fix(input string name, input lorenz_pkg::fix_t got,
		input lorenz_pkg::fix_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_sample(input string name, input lorenz_pkg::sample_t got,
		input lorenz_pkg::sample_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_channel(input string name, input lorenz_pkg::channel_e got,
		input lorenz_pkg::channel_e exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	// sink side of one four-phase transfer
	task automatic serve_word(input lorenz_pkg::channel_e exp_ch,
		input lorenz_pkg::sample_t exp_sample, input int delay);
		int count;
		int i;
		lorenz_pkg::sample_t held;
		lorenz_pkg::channel_e held_ch;
		count = 0;
		while (sample_req !== 1'b1 && count < WAIT_LIMIT) begin
			tick();
			count++;
		end
		if (sample_req !== 1'b1) begin
			failures++;
			$display("timeout: sample_req never went high for channel %0d", exp_ch);
			abort_run = 1'b1;
			return;
		end
		compare_channel("channel", channel, exp_ch);
		compare_sample("sample", sample, exp_sample);
		held = sample;
		held_ch = channel;
		// word must hold under back-pressure
		for (i = 0; i < delay; i++) begin
			tick();
			if (sample_req !== 1'b1) begin
				failures++;
				$display("sample_req dropped before sample_ack was given");
			end
			compare_sample("sample", sample, held);
			compare_channel("channel", channel, held_ch);
		end
		sample_ack = 1'b1;
		count = 0;
		while (sample_req === 1'b1 && count < WAIT_LIMIT) begin
			tick();
			count++;
			if (sample_req === 1'b1) begin
				compare_sample("sample", sample, held);
				compare_channel("channel", channel, held_ch);
			end
		end
		if (sample_req === 1'b1) begin
			failures++;
			$display("timeout: sample_req stayed high after sample_ack");
			abort_run = 1'b1;
			return;
		end
		// sink keeps ack up for a while after req falls
		for (i = 0; i < ACK_HOLD; i++) begin
			tick();
		end
		sample_ack = 1'b0;
	endtask

	// req must not rise on an edge where the DUT still saw ack high
	always @(negedge CLOCK_50) begin
		if (sample_req === 1'b1 && req_prev === 1'b0 && ack_prev === 1'b1) begin
			failures++;
			$display("sample_req rose while sample_ack was still high");
		end
		req_prev = sample_req;
		ack_prev = sample_ack;
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int frame_count;
		int k;
		int base;
		mismatches = 0;
		failures = 0;
		abort_run = 1'b0;
		req_prev = 1'b0;
		ack_prev = 1'b0;
		reset = 1'b0;
		run = 1'b0;
		sample_ack = 1'b0;
		for (k = 0; k < MAX_WORDS; k++) begin
			trace_mem[k] = 'x;
		end
		$readmemh("verification/lorenz_audio_trace.txt", trace_mem);
		x_init = word_to_fix(trace_mem[0]);
		y_init = word_to_fix(trace_mem[1]);
		z_init = word_to_fix(trace_mem[2]);
		sigma = word_to_fix(trace_mem[3]);
		rho = word_to_fix(trace_mem[4]);
		beta = word_to_fix(trace_mem[5]);
		frame_count = 0;
		if ($isunknown(trace_mem[6]) ||
			trace_mem[6] > (MAX_WORDS - HEADER_WORDS) / FRAME_WORDS) begin
			failures++;
			$display("trace file is missing or has a bad frame count");
		end else begin
			frame_count = int'(trace_mem[6]);
			// first frame's run must be set before its advance edge
			run = trace_mem[HEADER_WORDS][0];
		end

		// reset held for 3 cycles
		tick();
		tick();
		tick();
		if (sample_req !== 1'b0) begin
			failures++;
			$display("sample_req is not low during reset");
		end
		compare_fix("state_x", state_x, x_init);
		compare_fix("state_y", state_y, y_init);
		compare_fix("state_z", state_z, z_init);
		reset = 1'b1;

		for (k = 0; k < frame_count && !abort_run; k++) begin
			base = HEADER_WORDS + k * FRAME_WORDS;
			run = trace_mem[base][0];
			serve_word(lorenz_pkg::LEFT, trace_mem[base+6], int'(trace_mem[base+1]));
			if (!abort_run) begin
				// state stepped at this frame's advance edge
				compare_fix("state_x", state_x, word_to_fix(trace_mem[base+3]));
				compare_fix("state_y", state_y, word_to_fix(trace_mem[base+4]));
				compare_fix("state_z", state_z, word_to_fix(trace_mem[base+5]));
				serve_word(lorenz_pkg::RIGHT, trace_mem[base+6], int'(trace_mem[base+2]));
			end
		end

		$display("mismatches %0d, other failures %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- lorenz_audio.f
src/lorenz_pkg.sv
src/solver_if.sv
src/lorenz_solver.sv
src/note_lut.sv
src/sine_voice.sv
src/sample_sequencer.sv
src/lorenz_audio.sv
verification/lorenz_audio_tb.sv

//--- build.sh
#!/usr/bin/env bash
# compile and run the lorenz_audio testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f lorenz_audio.f --top-module lorenz_audio_tb -o lorenz_audio_sim

output="$(./obj_dir/lorenz_audio_sim)"
echo "$output"

# pass only when the testbench printed its pass line
echo "$output" | grep -q -x "TESTS PASSED"

//--- verification/lorenz_audio_trace.txt
// header: x_init y_init z_init sigma rho beta frame_count
// frame: run ack_delay_left ack_delay_right state_x state_y state_z sample
1000000 1000000 1000000 0000000 1000000 1000000 00000006
// frame 1, first euler step, all voices still at rom address 0
00000001 00000000 00000002 1000000 0FF0000 1000000 00000000
// frame 2
00000001 00000003 00000000 1000000 0FE0100 0FFF000 0012D800
// frame 3, z drops into note 15
00000001 00000001 00000005 1000000 0FD03FF 0FFD110 0025A400
// frame 4
00000001 00000000 00000000 1000000 0FC09DC 0FFA430 0025A400
// frames 5 and 6 run low, state holds, phases keep moving
00000000 00000004 00000001 1000000 0FC09DC 0FFA430 00387C00
00000000 00000002 00000003 1000000 0FC09DC 0FFA430 0044FC00
